// ==== Makefile ====
TB_TOP = l2_core_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f l2_core.f \
		--top-module $(TB_TOP) -o $(TB_TOP)

run: build
	./obj_dir/$(TB_TOP) | tee sim.log
	grep -q "Done: no errors" sim.log

lint:
	verilator --lint-only -Wall --timing -f l2_core.f --top-module l2_core

clean:
	rm -rf obj_dir sim.log

// ==== l2_core.f ====
+incdir+logic
logic/cache_types_pkg.sv
logic/cache_ctrl_pkg.sv
logic/l2_array_if.sv
logic/l2_fsm.sv
logic/l2_word_cnt.sv
logic/l2_localmem.sv
logic/l2_line_buf.sv
logic/l2_core.sv
tests/wb_mem_model.sv
tests/l2_core_tb.sv

// ==== logic/cache_ctrl_pkg.sv ====
package cache_ctrl_pkg;

    // per line state
    typedef enum logic [1:0] {
        INVALID,
        CLEAN,
        DIRTY
    } line_state_t;

    typedef enum logic [3:0] {
        IDLE,
        LOOKUP,
        WB_WORD,
        FILL_WORD,
        FILL_DONE,
        REPLY,
        FLUSH_RD,
        FLUSH_CHK,
        FLUSH_DONE
    } l2_fsm_state_t;

endpackage

// ==== logic/cache_defs.svh ====
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// base geometry
`define L2_ADDR_BITS 16
`define L2_WORD_BITS 32
`define L2_WORDS 4
`define L2_SETS 16

// bytes per word and byte offset width
`define L2_WORD_BYTES (`L2_WORD_BITS / 8)
`define L2_BOFF_BITS ($clog2(`L2_WORD_BYTES))

// address split, tag | set | word offset | byte offset
`define L2_SET_BITS ($clog2(`L2_SETS))
`define L2_WOFF_BITS ($clog2(`L2_WORDS))
`define L2_TAG_BITS (`L2_ADDR_BITS - `L2_SET_BITS - `L2_WOFF_BITS - `L2_BOFF_BITS)

`endif

// ==== logic/cache_types_pkg.sv ====
`include "cache_defs.svh"

package cache_types_pkg;

    // bus level vectors
    typedef logic [`L2_ADDR_BITS-1:0] addr_t;
    typedef logic [`L2_WORD_BITS-1:0] word_t;
    typedef logic [`L2_WORD_BYTES-1:0] sel_t;

    // address fields, the byte offset is dropped
    typedef logic [`L2_TAG_BITS-1:0] l2_tag_t;
    typedef logic [`L2_SET_BITS-1:0] l2_set_t;
    typedef logic [`L2_WOFF_BITS-1:0] word_offset_t;

    // word 0 sits in the low bits
    typedef word_t [`L2_WORDS-1:0] line_t;

endpackage

// ==== logic/l2_array_if.sv ====
`timescale 1ns/1ns

interface l2_array_if
    import cache_types_pkg::*, cache_ctrl_pkg::*;
();

    // from the controller
    l2_set_t     set;
    logic        rd_en;
    logic        wr_meta_en;
    l2_tag_t     wr_tag;
    line_state_t wr_state;

    // from the line buffer
    logic        wr_line_en;
    line_t       wr_line;

    // registered array outputs, valid one cycle after rd_en
    l2_tag_t     rd_tag;
    line_state_t rd_state;
    line_t       rd_line;

    modport ctrl (
        output set, rd_en, wr_meta_en, wr_tag, wr_state,
        input  rd_tag, rd_state
    );

    modport mem (
        input  set, rd_en, wr_meta_en, wr_tag, wr_state, wr_line_en, wr_line,
        output rd_tag, rd_state, rd_line
    );

    modport lbuf (
        output wr_line_en, wr_line,
        input  rd_line
    );

endinterface

// ==== logic/l2_core.sv ====
`timescale 1ns/1ns
`include "cache_defs.svh"

module l2_core
    import cache_types_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n_i,
    // cpu side, wishbone slave
    input  logic  cpu_cyc_i,
    input  logic  cpu_stb_i,
    input  logic  cpu_we_i,
    input  addr_t cpu_adr_i,
    input  word_t cpu_dat_i,
    input  sel_t  cpu_sel_i,
    output word_t cpu_dat_o,
    output logic  cpu_ack_o,
    // memory side, wishbone master
    output logic  mem_cyc_o,
    output logic  mem_stb_o,
    output logic  mem_we_o,
    output addr_t mem_adr_o,
    output word_t mem_dat_o,
    input  word_t mem_dat_i,
    input  logic  mem_ack_i,
    // flush handshake
    input  logic  flush_valid_i,
    output logic  flush_ready_o,
    output logic  flush_done_o
);

    l2_array_if arr_if();

    word_offset_t word_idx;
    word_offset_t word_sel;
    word_offset_t cpu_woff;
    l2_set_t      set_idx;
    logic         word_last, set_last;
    logic         word_clr, word_inc, set_clr, set_inc;
    logic         buf_load_line, buf_load_word, buf_merge, buf_store;
    word_t        buf_word;

    assign cpu_woff  = cpu_adr_i[`L2_BOFF_BITS +: `L2_WOFF_BITS];
    assign cpu_dat_o = buf_word;
    assign mem_dat_o = buf_word;

    l2_fsm fsm_u (
        .clk, .rst_n_i,
        .cpu_cyc_i, .cpu_stb_i, .cpu_we_i, .cpu_adr_i, .cpu_ack_o,
        .mem_cyc_o, .mem_stb_o, .mem_we_o, .mem_adr_o, .mem_ack_i,
        .flush_valid_i, .flush_ready_o, .flush_done_o,
        .arr             (arr_if.ctrl),
        .word_idx_i      (word_idx),
        .set_idx_i       (set_idx),
        .word_last_i     (word_last),
        .set_last_i      (set_last),
        .word_clr_o      (word_clr),
        .word_inc_o      (word_inc),
        .set_clr_o       (set_clr),
        .set_inc_o       (set_inc),
        .buf_load_line_o (buf_load_line),
        .buf_load_word_o (buf_load_word),
        .buf_merge_o     (buf_merge),
        .buf_store_o     (buf_store),
        .word_sel_o      (word_sel)
    );

    l2_word_cnt cnt_u (
        .clk, .rst_n_i,
        .word_clr_i  (word_clr),
        .word_inc_i  (word_inc),
        .set_clr_i   (set_clr),
        .set_inc_i   (set_inc),
        .word_idx_o  (word_idx),
        .set_idx_o   (set_idx),
        .word_last_o (word_last),
        .set_last_o  (set_last)
    );

    l2_localmem localmem_u (
        .clk, .rst_n_i,
        .arr (arr_if.mem)
    );

    l2_line_buf line_buf_u (
        .clk,
        .load_line_i       (buf_load_line),
        .load_word_i       (buf_load_word),
        .merge_i           (buf_merge),
        .store_i           (buf_store),
        .word_idx_i        (word_sel),
        .mem_dat_i, .cpu_dat_i, .cpu_sel_i,
        .cpu_word_offset_i (cpu_woff),
        .arr               (arr_if.lbuf),
        .word_o            (buf_word)
    );

endmodule

// ==== logic/l2_fsm.sv ====
`timescale 1ns/1ns
`include "cache_defs.svh"

module l2_fsm
    import cache_types_pkg::*, cache_ctrl_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         cpu_cyc_i,
    input  logic         cpu_stb_i,
    input  logic         cpu_we_i,
    input  addr_t        cpu_adr_i,
    output logic         cpu_ack_o,
    output logic         mem_cyc_o,
    output logic         mem_stb_o,
    output logic         mem_we_o,
    output addr_t        mem_adr_o,
    input  logic         mem_ack_i,
    input  logic         flush_valid_i,
    output logic         flush_ready_o,
    output logic         flush_done_o,
    l2_array_if.ctrl     arr,
    input  word_offset_t word_idx_i,
    input  l2_set_t      set_idx_i,
    input  logic         word_last_i,
    input  logic         set_last_i,
    output logic         word_clr_o,
    output logic         word_inc_o,
    output logic         set_clr_o,
    output logic         set_inc_o,
    output logic         buf_load_line_o,
    output logic         buf_load_word_o,
    output logic         buf_merge_o,
    output logic         buf_store_o,
    output word_offset_t word_sel_o
);

    l2_fsm_state_t state_q, state_d;
    l2_tag_t       victim_tag_q;
    logic          flushing_q;
    logic          gap_q;
    logic          idle_q;

    l2_tag_t       req_tag;
    l2_set_t       req_set;
    word_offset_t  req_off;
    logic          cpu_req;
    logic          hit;
    logic          mem_done;

    // request address decode
    assign req_tag = cpu_adr_i[`L2_ADDR_BITS-1 -: `L2_TAG_BITS];
    assign req_set = cpu_adr_i[`L2_BOFF_BITS + `L2_WOFF_BITS +: `L2_SET_BITS];
    assign req_off = cpu_adr_i[`L2_BOFF_BITS +: `L2_WOFF_BITS];

    assign cpu_req = cpu_cyc_i & cpu_stb_i;
    assign hit = (arr.rd_state != INVALID) && (arr.rd_tag == req_tag);

    // memory side, stb drops for one cycle after every ack
    assign mem_cyc_o = (state_q == WB_WORD) || (state_q == FILL_WORD);
    assign mem_stb_o = mem_cyc_o & ~gap_q;
    assign mem_we_o  = (state_q == WB_WORD);
    assign mem_done  = mem_stb_o & mem_ack_i;
    assign mem_adr_o = {mem_we_o ? victim_tag_q : req_tag, arr.set, word_idx_i,
                        {`L2_BOFF_BITS{1'b0}}};

    assign cpu_ack_o     = (state_q == REPLY);
    assign flush_done_o  = (state_q == FLUSH_DONE);
    assign flush_ready_o = idle_q & ~cpu_req;

    // flush walks the set counter, everything else follows the request
    assign arr.set    = flushing_q ? set_idx_i : req_set;
    assign arr.wr_tag = req_tag;
    assign word_sel_o = (state_q == REPLY) ? req_off : word_idx_i;

    always_comb begin
        state_d         = state_q;
        arr.rd_en       = 1'b0;
        arr.wr_meta_en  = 1'b0;
        arr.wr_state    = INVALID;
        word_clr_o      = 1'b0;
        word_inc_o      = 1'b0;
        set_clr_o       = 1'b0;
        set_inc_o       = 1'b0;
        buf_load_line_o = 1'b0;
        buf_load_word_o = 1'b0;
        buf_merge_o     = 1'b0;
        buf_store_o     = 1'b0;

        case (state_q)
            IDLE: begin
                if (cpu_req) begin
                    arr.rd_en = 1'b1;
                    state_d   = LOOKUP;
                end else if (flush_valid_i && flush_ready_o) begin
                    set_clr_o = 1'b1;
                    state_d   = FLUSH_RD;
                end
            end
            LOOKUP: begin
                // hit line or dirty victim, both go through the buffer
                buf_load_line_o = 1'b1;
                word_clr_o      = 1'b1;
                if (hit) begin
                    state_d = REPLY;
                end else if (arr.rd_state == DIRTY) begin
                    state_d = WB_WORD;
                end else begin
                    state_d = FILL_WORD;
                end
            end
            WB_WORD: begin
                if (mem_done) begin
                    word_inc_o = 1'b1;
                    if (word_last_i && flushing_q) begin
                        arr.wr_meta_en = 1'b1;
                        if (set_last_i) begin
                            state_d = FLUSH_DONE;
                        end else begin
                            set_inc_o = 1'b1;
                            state_d   = FLUSH_RD;
                        end
                    end else if (word_last_i) begin
                        state_d = FILL_WORD;
                    end
                end
            end
            FILL_WORD: begin
                if (mem_done) begin
                    buf_load_word_o = 1'b1;
                    word_inc_o      = 1'b1;
                    if (word_last_i) begin
                        state_d = FILL_DONE;
                    end
                end
            end
            FILL_DONE: begin
                buf_store_o    = 1'b1;
                arr.wr_meta_en = 1'b1;
                arr.wr_state   = CLEAN;
                state_d        = REPLY;
            end
            REPLY: begin
                // writes land here for hits and refilled misses alike
                if (cpu_we_i) begin
                    buf_merge_o    = 1'b1;
                    buf_store_o    = 1'b1;
                    arr.wr_meta_en = 1'b1;
                    arr.wr_state   = DIRTY;
                end
                state_d = IDLE;
            end
            FLUSH_RD: begin
                arr.rd_en = 1'b1;
                state_d   = FLUSH_CHK;
            end
            FLUSH_CHK: begin
                if (arr.rd_state == DIRTY) begin
                    buf_load_line_o = 1'b1;
                    word_clr_o      = 1'b1;
                    state_d         = WB_WORD;
                end else begin
                    arr.wr_meta_en = 1'b1;
                    if (set_last_i) begin
                        state_d = FLUSH_DONE;
                    end else begin
                        set_inc_o = 1'b1;
                        state_d   = FLUSH_RD;
                    end
                end
            end
            FLUSH_DONE: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q    <= IDLE;
            flushing_q <= 1'b0;
            gap_q      <= 1'b0;
            idle_q     <= 1'b0;
        end else begin
            state_q <= state_d;
            gap_q   <= mem_done;
            idle_q  <= (state_d == IDLE);
            if (set_clr_o) begin
                flushing_q <= 1'b1;
            end else if (state_q == FLUSH_DONE) begin
                flushing_q <= 1'b0;
            end
        end
    end

    // tag of the line about to be written back
    always_ff @(posedge clk) begin
        if (state_q == LOOKUP || state_q == FLUSH_CHK) begin
            victim_tag_q <= arr.rd_tag;
        end
    end

endmodule

// ==== logic/l2_line_buf.sv ====
`timescale 1ns/1ns
`include "cache_defs.svh"

module l2_line_buf
    import cache_types_pkg::*;
(
    input  logic         clk,
    input  logic         load_line_i,
    input  logic         load_word_i,
    input  logic         merge_i,
    input  logic         store_i,
    input  word_offset_t word_idx_i,
    input  word_t        mem_dat_i,
    input  word_t        cpu_dat_i,
    input  sel_t         cpu_sel_i,
    input  word_offset_t cpu_word_offset_i,
    l2_array_if.lbuf     arr,
    output word_t        word_o
);

    line_t line_q;
    line_t line_d;
    word_t merged;

    always_comb begin
        line_d = line_q;
        if (load_line_i) begin
            line_d = arr.rd_line;
        end
        if (load_word_i) begin
            line_d[word_idx_i] = mem_dat_i;
        end
        // byte merge of the cpu write data
        merged = line_d[cpu_word_offset_i];
        for (int b = 0; b < `L2_WORD_BYTES; b++) begin
            if (cpu_sel_i[b]) begin
                merged[8*b +: 8] = cpu_dat_i[8*b +: 8];
            end
        end
        if (merge_i) begin
            line_d[cpu_word_offset_i] = merged;
        end
    end

    always_ff @(posedge clk) begin
        line_q <= line_d;
    end

    // store takes the merged line in the same cycle
    assign arr.wr_line_en = store_i;
    assign arr.wr_line    = line_d;

    assign word_o = line_q[word_idx_i];

endmodule

// ==== logic/l2_localmem.sv ====
`timescale 1ns/1ns
`include "cache_defs.svh"

module l2_localmem
    import cache_types_pkg::*, cache_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n_i,
    l2_array_if.mem arr
);

    l2_tag_t     tag_mem   [`L2_SETS];
    line_state_t state_mem [`L2_SETS];
    line_t       line_mem  [`L2_SETS];

    // state array, all lines invalid out of reset
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            for (int s = 0; s < `L2_SETS; s++) begin
                state_mem[s] <= INVALID;
            end
        end else if (arr.wr_meta_en) begin
            state_mem[arr.set] <= arr.wr_state;
        end
    end

    // tag array shares the meta write enable
    always_ff @(posedge clk) begin
        if (arr.wr_meta_en) begin
            tag_mem[arr.set] <= arr.wr_tag;
        end
    end

    // line data written separately by the line buffer
    always_ff @(posedge clk) begin
        if (arr.wr_line_en) begin
            line_mem[arr.set] <= arr.wr_line;
        end
    end

    // synchronous read, outputs hold until the next rd_en
    always_ff @(posedge clk) begin
        if (arr.rd_en) begin
            arr.rd_tag   <= tag_mem[arr.set];
            arr.rd_state <= state_mem[arr.set];
            arr.rd_line  <= line_mem[arr.set];
        end
    end

endmodule

// ==== logic/l2_word_cnt.sv ====
`timescale 1ns/1ns
`include "cache_defs.svh"

module l2_word_cnt
    import cache_types_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n_i,
    input  logic         word_clr_i,
    input  logic         word_inc_i,
    input  logic         set_clr_i,
    input  logic         set_inc_i,
    output word_offset_t word_idx_o,
    output l2_set_t      set_idx_o,
    output logic         word_last_o,
    output logic         set_last_o
);

    word_offset_t word_q;
    l2_set_t      set_q;

    // word within a burst, wraps back to 0 after the last word
    always_ff @(posedge clk) begin
        if (!rst_n_i || word_clr_i) begin
            word_q <= '0;
        end else if (word_inc_i) begin
            word_q <= word_q + 1'b1;
        end
    end

    // set within a flush walk
    always_ff @(posedge clk) begin
        if (!rst_n_i || set_clr_i) begin
            set_q <= '0;
        end else if (set_inc_i) begin
            set_q <= set_q + 1'b1;
        end
    end

    assign word_idx_o  = word_q;
    assign set_idx_o   = set_q;
    assign word_last_o = (word_q == word_offset_t'(`L2_WORDS - 1));
    assign set_last_o  = (set_q == l2_set_t'(`L2_SETS - 1));

endmodule

// ==== tests/l2_core_tb.sv ====
`timescale 1ns/1ns

module l2_core_tb
    import cache_types_pkg::*;
();

    localparam int ack_limit   = 200;
    localparam int flush_limit = 4000;

    logic  clk;
    logic  rst_n;
    logic  cpu_cyc, cpu_stb, cpu_we, cpu_ack;
    addr_t cpu_adr;
    word_t cpu_wdat, cpu_rdat;
    sel_t  cpu_sel;
    logic  mem_cyc, mem_stb, mem_we, mem_ack;
    addr_t mem_adr;
    word_t mem_wdat, mem_rdat;
    logic  flush_valid, flush_ready, flush_done;

    // expected memory contents as seen from the cpu
    word_t  shadow [addr_t];
    integer seed;
    int     errors = 0;
    int     timeouts = 0;
    int     checks = 0;
    int     mem_xfer_cnt = 0;
    int     mem_rd_cnt = 0;
    int     done_cnt = 0;
    int     last_lat;
    word_t  last_rdat;

    l2_core i_l2_core (
        .clk (clk), .rst_n_i (rst_n),
        .cpu_cyc_i (cpu_cyc), .cpu_stb_i (cpu_stb), .cpu_we_i (cpu_we),
        .cpu_adr_i (cpu_adr), .cpu_dat_i (cpu_wdat), .cpu_sel_i (cpu_sel),
        .cpu_dat_o (cpu_rdat), .cpu_ack_o (cpu_ack),
        .mem_cyc_o (mem_cyc), .mem_stb_o (mem_stb), .mem_we_o (mem_we),
        .mem_adr_o (mem_adr), .mem_dat_o (mem_wdat),
        .mem_dat_i (mem_rdat), .mem_ack_i (mem_ack),
        .flush_valid_i (flush_valid), .flush_ready_o (flush_ready),
        .flush_done_o (flush_done)
    );

    wb_mem_model mem_model (
        .clk (clk), .rst_n_i (rst_n),
        .cyc_i (mem_cyc), .stb_i (mem_stb), .we_i (mem_we),
        .adr_i (mem_adr), .dat_i (mem_wdat), .dat_o (mem_rdat), .ack_o (mem_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // transfers complete on the edge after a negedge with stb and ack high
    always @(negedge clk) begin
        if (mem_stb && mem_ack) begin
            mem_xfer_cnt <= mem_xfer_cnt + 1;
            if (!mem_we) begin
                mem_rd_cnt <= mem_rd_cnt + 1;
            end
        end
        if (flush_done) begin
            done_cnt <= done_cnt + 1;
        end
    end

    function automatic addr_t make_addr(l2_tag_t tag, l2_set_t idx, word_offset_t off);
        return {tag, idx, off, 2'b00};
    endfunction

    function automatic word_t expected(addr_t a);
        return shadow.exists(a) ? shadow[a] : (word_t'(a) ^ 32'h5a5a0000);
    endfunction

    function automatic void shadow_write(addr_t a, word_t d, sel_t sel);
        word_t w;
        w = expected(a);
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                w[8*b +: 8] = d[8*b +: 8];
            end
        end
        shadow[a] = w;
    endfunction

    task automatic check_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic cpu_access(input logic we, input addr_t a, input word_t d, input sel_t sel);
        int n;
        n = 0;
        @(posedge clk);
        cpu_cyc  <= 1'b1;
        cpu_stb  <= 1'b1;
        cpu_we   <= we;
        cpu_adr  <= a;
        cpu_wdat <= d;
        cpu_sel  <= sel;
        do begin
            @(negedge clk);
            n++;
        end while (!cpu_ack && n < ack_limit);
        if (!cpu_ack) begin
            timeouts++;
            $display("timed out waiting for the cpu ack at address %h", a);
        end
        last_lat  = n;
        last_rdat = cpu_rdat;
        @(posedge clk);
        cpu_cyc <= 1'b0;
        cpu_stb <= 1'b0;
        cpu_we  <= 1'b0;
    endtask

    task automatic write_word(input addr_t a, input word_t d, input sel_t sel);
        cpu_access(1'b1, a, d, sel);
        shadow_write(a, d, sel);
    endtask

    task automatic read_check(input addr_t a);
        cpu_access(1'b0, a, '0, '0);
        check_eq($sformatf("read data at %h", a), last_rdat, expected(a));
    endtask

    task automatic flush_all();
        int n;
        n = 0;
        @(posedge clk);
        flush_valid <= 1'b1;
        do begin
            @(negedge clk);
            n++;
        end while (!flush_ready && n < ack_limit);
        if (!flush_ready) begin
            timeouts++;
            $display("timed out waiting for the cache to accept the flush");
        end
        @(posedge clk);
        flush_valid <= 1'b0;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!flush_done && n < flush_limit);
        if (!flush_done) begin
            timeouts++;
            $display("timed out waiting for the flush to finish");
        end
    endtask

    initial begin
        addr_t a;
        addr_t b;
        int    xfers;
        int    reads;
        int    dones;
        int    wb_n;

        rst_n       = 1'b0;
        cpu_cyc     = 1'b0;
        cpu_stb     = 1'b0;
        cpu_we      = 1'b0;
        cpu_adr     = '0;
        cpu_wdat    = '0;
        cpu_sel     = '0;
        flush_valid = 1'b0;
        seed        = 32'h998f;

        repeat (7) @(posedge clk);
        @(negedge clk);
        check_eq("outputs in reset", {cpu_ack, mem_cyc, mem_stb, mem_we, flush_done,
                                      flush_ready}, '0);
        @(posedge clk);
        rst_n <= 1'b1;

        // cold reads see the memory pattern
        read_check(make_addr(8'h12, 4'h3, 2'h1));
        read_check(make_addr(8'hc7, 4'he, 2'h0));

        // partial write then a hit read
        a = make_addr(8'h21, 4'h5, 2'h2);
        write_word(a, 32'hdeadbeef, 4'b0101);
        xfers = mem_xfer_cnt;
        read_check(a);
        check_eq("memory transfers between hit acks", mem_xfer_cnt - xfers, 0);
        check_eq("hit latency in cycles", last_lat, 3);
        write_word(a, 32'h77665544, 4'b1000);
        read_check(a);

        // dirty victim is written back in word order
        a = make_addr(8'h40, 4'h9, 2'h1);
        b = make_addr(8'h41, 4'h9, 2'h3);
        write_word(a, 32'h13572468, 4'b1111);
        mem_model.clear_log();
        read_check(b);
        wb_n = mem_model.log_count();
        check_eq("writeback word count", wb_n, 4);
        for (int i = 0; i < wb_n && i < 4; i++) begin
            check_eq("writeback address", mem_model.log_adr_at(i),
                     make_addr(8'h40, 4'h9, word_offset_t'(i)));
            check_eq("writeback data", mem_model.log_dat_at(i),
                     expected(make_addr(8'h40, 4'h9, word_offset_t'(i))));
        end
        read_check(a);

        // flush leaves memory equal to the shadow
        for (int i = 0; i < 6; i++) begin
            write_word(make_addr(8'h60, l2_set_t'(i), word_offset_t'(i)),
                       32'h0bad0000 + i, (i % 2) ? 4'b0110 : 4'b1111);
        end
        dones = done_cnt;
        flush_all();
        foreach (shadow[s]) begin
            check_eq($sformatf("memory at %h after flush", s), mem_model.peek(s), shadow[s]);
        end
        reads = mem_rd_cnt;
        read_check(make_addr(8'h60, 4'h2, 2'h2));
        check_eq("refill reads after flush", mem_rd_cnt - reads, 4);
        check_eq("flush_done pulses", done_cnt - dones, 1);

        // random traffic over 4 tags and all sets
        for (int i = 0; i < 200; i++) begin
            a = make_addr(l2_tag_t'($random(seed) & 3), l2_set_t'($random(seed)),
                          word_offset_t'($random(seed)));
            if ($random(seed) & 1) begin
                write_word(a, word_t'($random(seed)), sel_t'($random(seed)));
            end else begin
                read_check(a);
            end
        end

        $display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// ==== tests/wb_mem_model.sv ====
`timescale 1ns/1ns

module wb_mem_model
    import cache_types_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n_i,
    input  logic  cyc_i,
    input  logic  stb_i,
    input  logic  we_i,
    input  addr_t adr_i,
    input  word_t dat_i,
    output word_t dat_o,
    output logic  ack_o
);

    word_t  mem_words [addr_t];
    addr_t  log_adr [$];
    word_t  log_dat [$];
    integer seed = 32'h998f;
    int     wait_left;
    logic   busy;

    // never written words read back as address xor a fixed pattern
    function automatic word_t peek(addr_t a);
        return mem_words.exists(a) ? mem_words[a] : (word_t'(a) ^ 32'h5a5a0000);
    endfunction

    function automatic void clear_log();
        log_adr.delete();
        log_dat.delete();
    endfunction

    function automatic int log_count();
        return log_adr.size();
    endfunction

    function automatic addr_t log_adr_at(int i);
        return log_adr[i];
    endfunction

    function automatic word_t log_dat_at(int i);
        return log_dat[i];
    endfunction

    // random wait of 0 to 3 cycles before each ack
    always @(posedge clk) begin
        if (!rst_n_i) begin
            ack_o <= 1'b0;
            dat_o <= '0;
            busy  <= 1'b0;
        end else if (ack_o) begin
            ack_o <= 1'b0;
        end else if (cyc_i && stb_i) begin
            if (!busy) begin
                busy      <= 1'b1;
                wait_left <= $random(seed) & 3;
            end else if (wait_left == 0) begin
                busy  <= 1'b0;
                ack_o <= 1'b1;
                if (we_i) begin
                    mem_words[adr_i] = dat_i;
                    log_adr.push_back(adr_i);
                    log_dat.push_back(dat_i);
                end else begin
                    dat_o <= peek(adr_i);
                end
            end else begin
                wait_left <= wait_left - 1;
            end
        end
    end

endmodule
